// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+test
common/rv_decode_pkg.sv
decode/base_op_decode.sv
decode/system_decode.sv
decode/decode_control.sv
decode/decode_stage.sv
test/decode_stage_tb.sv

// File: common/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int CSR_IDX_W  = 12;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int CSR_UIMM_W = 5;
    // shift flag on top of the 4-bit alu code
    localparam int ALU_CTRL_W = 5;

    localparam logic [FUNCT7_W-1:0]  F7_BASE        = 7'b0000000;
    localparam logic [FUNCT7_W-1:0]  F7_ALT         = 7'b0100000;
    localparam logic [CSR_IDX_W-1:0] FUNCT12_ECALL  = 12'h000;
    localparam logic [CSR_IDX_W-1:0] FUNCT12_EBREAK = 12'h001;

    // major opcode groups taken from opcode bits 6..2
    typedef enum logic [4:0]
    {
        GRP_LOAD      = 5'b00000,
        GRP_MISC_MEM  = 5'b00011,
        GRP_ARITH_IMM = 5'b00100,
        GRP_AUIPC     = 5'b00101,
        GRP_STORE     = 5'b01000,
        GRP_ARITH_REG = 5'b01100,
        GRP_LUI       = 5'b01101,
        GRP_BRANCH    = 5'b11000,
        GRP_JALR      = 5'b11001,
        GRP_JAL       = 5'b11011,
        GRP_SYSTEM    = 5'b11100
    } opgroup_e;

    typedef enum logic [5:0]
    {
        OP_NONE = 6'd0,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI,
        OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI,
        OP_AUIPC,
        OP_SB, OP_SH, OP_SW,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LUI,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JALR, OP_JAL,
        OP_FENCE, OP_FENCE_I,
        OP_SYSTEM,
        OP_ILLEGAL
    } base_op_e;

    typedef enum logic [3:0]
    {
        SYS_ECALL = 4'd0,
        SYS_EBREAK,
        SYS_CSRRW, SYS_CSRRS, SYS_CSRRC,
        SYS_CSRRWI, SYS_CSRRSI, SYS_CSRRCI,
        SYS_ILLEGAL
    } sys_op_e;

    // compares have bit 3 set
    typedef enum logic [3:0]
    {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_XOR  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_AND  = 4'h4,
        ALU_SHL  = 4'h5,
        ALU_SHR  = 4'h6,
        ALU_EQ   = 4'h8,
        ALU_NEQ  = 4'h9,
        ALU_LTS  = 4'ha,
        ALU_LTU  = 4'hb,
        ALU_NLTS = 4'hc,
        ALU_NLTU = 4'hd
    } alu_ctrl_e;

    typedef enum logic [1:0]
    {
        RES_ALU    = 2'd0,
        RES_MEMORY = 2'd1,
        RES_PC_P4  = 2'd2
    } res_src_e;

    typedef enum logic [1:0]
    {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_RC   = 2'd3
    } csr_op_e;

endpackage

// File: decode/base_op_decode.sv
`timescale 1ns/100ps

module base_op_decode
    import rv_decode_pkg::*;
(
    input  logic [XLEN-1:0] i_instr,
    output base_op_e        o_op
);

    logic [FUNCT3_W-1:0] w_funct3;
    logic [FUNCT7_W-1:0] w_funct7;
    logic                w_full;
    opgroup_e            w_group;

    assign w_funct3 = i_instr[14:12];
    assign w_funct7 = i_instr[31:25];
    // 16-bit encodings have bits 1..0 other than 11
    assign w_full   = (i_instr[1:0] == 2'b11);
    assign w_group  = opgroup_e'(i_instr[6:2]);

    always_comb
    begin
        o_op = OP_ILLEGAL;
        if (i_instr == '0)
            o_op = OP_NONE;
        else if (w_full)
        begin
            case (w_group)
            GRP_LOAD:
                case (w_funct3)
                3'b000:  o_op = OP_LB;
                3'b001:  o_op = OP_LH;
                3'b010:  o_op = OP_LW;
                3'b100:  o_op = OP_LBU;
                3'b101:  o_op = OP_LHU;
                default: o_op = OP_ILLEGAL;
                endcase
            GRP_MISC_MEM:
                case (w_funct3)
                3'b000:  o_op = OP_FENCE;
                3'b001:  o_op = OP_FENCE_I;
                default: o_op = OP_ILLEGAL;
                endcase
            GRP_ARITH_IMM:
                case (w_funct3)
                3'b000:  o_op = OP_ADDI;
                3'b001:  o_op = (w_funct7 == F7_BASE) ? OP_SLLI : OP_ILLEGAL;
                3'b010:  o_op = OP_SLTI;
                3'b011:  o_op = OP_SLTIU;
                3'b100:  o_op = OP_XORI;
                3'b101:
                begin
                    if (w_funct7 == F7_BASE)
                        o_op = OP_SRLI;
                    else if (w_funct7 == F7_ALT)
                        o_op = OP_SRAI;
                    else
                        o_op = OP_ILLEGAL;
                end
                3'b110:  o_op = OP_ORI;
                default: o_op = OP_ANDI;
                endcase
            GRP_AUIPC:
                o_op = OP_AUIPC;
            GRP_STORE:
                case (w_funct3)
                3'b000:  o_op = OP_SB;
                3'b001:  o_op = OP_SH;
                3'b010:  o_op = OP_SW;
                default: o_op = OP_ILLEGAL;
                endcase
            GRP_ARITH_REG:
                // funct7 and funct3 together pick the op
                case ({w_funct7, w_funct3})
                {F7_BASE, 3'b000}: o_op = OP_ADD;
                {F7_ALT,  3'b000}: o_op = OP_SUB;
                {F7_BASE, 3'b001}: o_op = OP_SLL;
                {F7_BASE, 3'b010}: o_op = OP_SLT;
                {F7_BASE, 3'b011}: o_op = OP_SLTU;
                {F7_BASE, 3'b100}: o_op = OP_XOR;
                {F7_BASE, 3'b101}: o_op = OP_SRL;
                {F7_ALT,  3'b101}: o_op = OP_SRA;
                {F7_BASE, 3'b110}: o_op = OP_OR;
                {F7_BASE, 3'b111}: o_op = OP_AND;
                default:           o_op = OP_ILLEGAL;
                endcase
            GRP_LUI:
                o_op = OP_LUI;
            GRP_BRANCH:
                case (w_funct3)
                3'b000:  o_op = OP_BEQ;
                3'b001:  o_op = OP_BNE;
                3'b100:  o_op = OP_BLT;
                3'b101:  o_op = OP_BGE;
                3'b110:  o_op = OP_BLTU;
                3'b111:  o_op = OP_BGEU;
                default: o_op = OP_ILLEGAL;
                endcase
            GRP_JALR:
                o_op = (w_funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
            GRP_JAL:
                o_op = OP_JAL;
            GRP_SYSTEM:
                // refined by system_decode
                o_op = OP_SYSTEM;
            default:
                o_op = OP_ILLEGAL;
            endcase
        end
    end

endmodule

// File: decode/decode_control.sv
`timescale 1ns/100ps

module decode_control
    import rv_decode_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_flush,
    input  logic [XLEN-1:0]       i_instr,
    input  base_op_e              i_op,
    input  sys_op_e               i_sys_op,
    output logic [REG_IDX_W-1:0]  o_rs1,
    output logic [REG_IDX_W-1:0]  o_rs2,
    output logic [REG_IDX_W-1:0]  o_rd,
    output logic [XLEN-1:0]       o_imm,
    output logic                  o_reg_write,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_jump,
    output logic                  o_jump_imm,
    output logic                  o_branch,
    output logic                  o_pc_sel,
    output logic                  o_alu_op1_sel,
    output logic                  o_alu_op2_sel,
    output logic [FUNCT3_W-1:0]   o_funct3,
    output logic [ALU_CTRL_W-1:0] o_alu_ctrl,
    output res_src_e              o_res_src,
    output logic [CSR_IDX_W-1:0]  o_csr_idx,
    output csr_op_e               o_csr_op,
    output logic                  o_csr_sel,
    output logic                  o_inv_instr
);

    logic      w_load, w_store, w_arith_imm, w_arith_reg, w_branch;
    logic      w_lui, w_auipc, w_jal, w_jalr;
    logic      w_system, w_csr, w_csr_imm;
    logic      w_inv, w_valid;
    logic      w_reg_write, w_op1_pc, w_op2_imm, w_alu_arith;
    alu_ctrl_e w_alu_ctrl;
    res_src_e  w_res_src;
    csr_op_e   w_csr_op;
    logic [XLEN-1:0] w_imm;

    assign w_load      = i_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign w_store     = i_op inside {OP_SB, OP_SH, OP_SW};
    assign w_arith_imm = i_op inside {OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI,
                                      OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI};
    assign w_arith_reg = i_op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                                      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    assign w_branch    = i_op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    assign w_lui       = (i_op == OP_LUI);
    assign w_auipc     = (i_op == OP_AUIPC);
    assign w_jal       = (i_op == OP_JAL);
    assign w_jalr      = (i_op == OP_JALR);

    assign w_system  = (i_op == OP_SYSTEM);
    assign w_csr     = w_system & (i_sys_op inside {SYS_CSRRW, SYS_CSRRS, SYS_CSRRC,
                                                    SYS_CSRRWI, SYS_CSRRSI, SYS_CSRRCI});
    assign w_csr_imm = w_system & (i_sys_op inside {SYS_CSRRWI, SYS_CSRRSI, SYS_CSRRCI});

    // ecall and ebreak are reported invalid so the core traps on them
    assign w_inv   = (i_op == OP_ILLEGAL) |
                     (w_system & (i_sys_op inside {SYS_ECALL, SYS_EBREAK, SYS_ILLEGAL}));
    assign w_valid = !w_inv;

    assign w_reg_write = w_load | w_arith_imm | w_arith_reg | w_lui | w_auipc |
                         w_jal | w_jalr | w_csr;
    assign w_op1_pc    = w_auipc | w_jal;
    assign w_op2_imm   = w_auipc | w_jal | w_jalr | w_lui | w_arith_imm | w_load | w_store;
    assign w_alu_arith = i_op inside {OP_SRAI, OP_SRA};

    always_comb
    begin
        case (1'b1)
        w_jal:
            w_imm = {{(XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                     i_instr[30:21], 1'b0};
        w_lui | w_auipc:
            w_imm = {i_instr[31:12], 12'b0};
        w_jalr | w_load | w_arith_imm:
            w_imm = {{(XLEN-11){i_instr[31]}}, i_instr[30:20]};
        w_branch:
            w_imm = {{(XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                     i_instr[11:8], 1'b0};
        w_store:
            w_imm = {{(XLEN-11){i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
        w_csr_imm:
            w_imm = {{(XLEN-CSR_UIMM_W){1'b0}}, i_instr[19:15]};
        default:
            w_imm = '0;
        endcase
    end

    always_comb
    begin
        case (i_op)
        OP_BEQ:                          w_alu_ctrl = ALU_EQ;
        OP_BNE:                          w_alu_ctrl = ALU_NEQ;
        OP_SLTI, OP_SLT, OP_BLT:         w_alu_ctrl = ALU_LTS;
        OP_SLTIU, OP_SLTU, OP_BLTU:      w_alu_ctrl = ALU_LTU;
        OP_BGE:                          w_alu_ctrl = ALU_NLTS;
        OP_BGEU:                         w_alu_ctrl = ALU_NLTU;
        OP_SUB:                          w_alu_ctrl = ALU_SUB;
        OP_XORI, OP_XOR:                 w_alu_ctrl = ALU_XOR;
        OP_ORI, OP_OR:                   w_alu_ctrl = ALU_OR;
        OP_ANDI, OP_AND:                 w_alu_ctrl = ALU_AND;
        OP_SLLI, OP_SLL:                 w_alu_ctrl = ALU_SHL;
        OP_SRLI, OP_SRL, OP_SRAI, OP_SRA: w_alu_ctrl = ALU_SHR;
        default:                         w_alu_ctrl = ALU_ADD;
        endcase
    end

    always_comb
    begin
        if (w_load)
            w_res_src = RES_MEMORY;
        else if (w_jal | w_jalr)
            w_res_src = RES_PC_P4;
        else
            w_res_src = RES_ALU;
    end

    always_comb
    begin
        w_csr_op = CSR_NONE;
        if (w_system)
        begin
            case (i_sys_op)
            SYS_CSRRW, SYS_CSRRWI: w_csr_op = CSR_RW;
            SYS_CSRRS, SYS_CSRRSI: w_csr_op = CSR_RS;
            SYS_CSRRC, SYS_CSRRCI: w_csr_op = CSR_RC;
            default:               w_csr_op = CSR_NONE;
            endcase
        end
    end

    // reset and flush load a bubble into the decode/execute register
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            o_rs1         <= '0;
            o_rs2         <= '0;
            o_rd          <= '0;
            o_imm         <= '0;
            o_reg_write   <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_write   <= 1'b0;
            o_jump        <= 1'b0;
            o_jump_imm    <= 1'b0;
            o_branch      <= 1'b0;
            o_pc_sel      <= 1'b0;
            o_alu_op1_sel <= 1'b0;
            o_alu_op2_sel <= 1'b0;
            o_funct3      <= '0;
            o_alu_ctrl    <= {1'b0, ALU_ADD};
            o_res_src     <= RES_ALU;
            o_csr_idx     <= '0;
            o_csr_op      <= CSR_NONE;
            o_csr_sel     <= 1'b0;
            o_inv_instr   <= 1'b0;
        end
        else
        begin
            o_rs1         <= w_lui ? '0 : i_instr[19:15];
            o_rs2         <= i_instr[24:20];
            o_rd          <= i_instr[11:7];
            o_imm         <= w_imm;
            o_funct3      <= i_instr[14:12];
            o_csr_idx     <= i_instr[31:20];
            // controls of an invalid word are dropped
            o_reg_write   <= w_valid & w_reg_write;
            o_mem_read    <= w_valid & w_load;
            o_mem_write   <= w_valid & w_store;
            o_jump        <= w_valid & (w_jal | w_jalr);
            o_jump_imm    <= w_valid & w_jal;
            o_branch      <= w_valid & w_branch;
            o_pc_sel      <= w_valid & w_jalr;
            o_alu_op1_sel <= w_valid & w_op1_pc;
            o_alu_op2_sel <= w_valid & w_op2_imm;
            o_alu_ctrl    <= w_valid ? {w_alu_arith, w_alu_ctrl} : {1'b0, ALU_ADD};
            o_res_src     <= w_valid ? w_res_src : RES_ALU;
            o_csr_op      <= w_valid ? w_csr_op : CSR_NONE;
            o_csr_sel     <= w_valid & w_csr_imm;
            o_inv_instr   <= w_inv;
        end
    end

    a_mem_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_mem_read && o_mem_write));

    a_inv_no_write: assert property (@(posedge i_clk) disable iff (i_reset)
        o_inv_instr |-> !o_reg_write);

    a_jump_imm: assert property (@(posedge i_clk) disable iff (i_reset)
        o_jump_imm |-> o_jump);

endmodule

// File: decode/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_flush,
    input  logic [XLEN-1:0]       i_instr,
    output logic [REG_IDX_W-1:0]  o_rs1,
    output logic [REG_IDX_W-1:0]  o_rs2,
    output logic [REG_IDX_W-1:0]  o_rd,
    output logic [XLEN-1:0]       o_imm,
    output logic                  o_reg_write,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_jump,
    output logic                  o_jump_imm,
    output logic                  o_branch,
    output logic                  o_pc_sel,
    output logic                  o_alu_op1_sel,
    output logic                  o_alu_op2_sel,
    output logic [FUNCT3_W-1:0]   o_funct3,
    output logic [ALU_CTRL_W-1:0] o_alu_ctrl,
    output res_src_e              o_res_src,
    output logic [CSR_IDX_W-1:0]  o_csr_idx,
    output csr_op_e               o_csr_op,
    output logic                  o_csr_sel,
    output logic                  o_inv_instr
);

    base_op_e w_op;
    sys_op_e  w_sys_op;

    // both classifiers see the raw word in parallel
    base_op_decode u_base_op_decode
    (
        .i_instr (i_instr),
        .o_op    (w_op)
    );

    system_decode u_system_decode
    (
        .i_instr  (i_instr),
        .o_sys_op (w_sys_op)
    );

    decode_control u_decode_control
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_flush       (i_flush),
        .i_instr       (i_instr),
        .i_op          (w_op),
        .i_sys_op      (w_sys_op),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_imm         (o_imm),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_jump_imm    (o_jump_imm),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_funct3      (o_funct3),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_res_src     (o_res_src),
        .o_csr_idx     (o_csr_idx),
        .o_csr_op      (o_csr_op),
        .o_csr_sel     (o_csr_sel),
        .o_inv_instr   (o_inv_instr)
    );

endmodule

// File: decode/system_decode.sv
`timescale 1ns/100ps

module system_decode
    import rv_decode_pkg::*;
(
    input  logic [XLEN-1:0] i_instr,
    output sys_op_e         o_sys_op
);

    logic [FUNCT3_W-1:0]  w_funct3;
    logic [CSR_IDX_W-1:0] w_funct12;

    assign w_funct3  = i_instr[14:12];
    assign w_funct12 = i_instr[31:20];

    // only meaningful when the opcode is the system group
    always_comb
    begin
        o_sys_op = SYS_ILLEGAL;
        case (w_funct3)
        3'b000:
        begin
            if (w_funct12 == FUNCT12_ECALL)
                o_sys_op = SYS_ECALL;
            else if (w_funct12 == FUNCT12_EBREAK)
                o_sys_op = SYS_EBREAK;
            else
                o_sys_op = SYS_ILLEGAL;
        end
        3'b001:  o_sys_op = SYS_CSRRW;
        3'b010:  o_sys_op = SYS_CSRRS;
        3'b011:  o_sys_op = SYS_CSRRC;
        3'b101:  o_sys_op = SYS_CSRRWI;
        3'b110:  o_sys_op = SYS_CSRRSI;
        3'b111:  o_sys_op = SYS_CSRRCI;
        default: o_sys_op = SYS_ILLEGAL;
        endcase
    end

endmodule

// File: test/decode_vectors.svh
// control patterns from bit 10 down to 0
// reg_write mem_read mem_write jump jump_imm branch pc_sel op1_pc op2_imm csr_sel inv
localparam logic [10:0] C_NONE    = 11'b000_0000_0000;
localparam logic [10:0] C_WRITE   = 11'b100_0000_0000;
localparam logic [10:0] C_ARITH_I = 11'b100_0000_0100;
localparam logic [10:0] C_LOAD    = 11'b110_0000_0100;
localparam logic [10:0] C_STORE   = 11'b001_0000_0100;
localparam logic [10:0] C_BRANCH  = 11'b000_0010_0000;
localparam logic [10:0] C_JAL     = 11'b100_1100_1100;
localparam logic [10:0] C_JALR    = 11'b100_1001_0100;
localparam logic [10:0] C_AUIPC   = 11'b100_0000_1100;
localparam logic [10:0] C_CSR_I   = 11'b100_0000_0010;
localparam logic [10:0] C_INV     = 11'b000_0000_0001;

task automatic load_vectors();
    // name, word, random fields, flush, controls, alu ctrl, result, csr op, immediate
    add_row("add",    32'h00000033, FMT_R, 0, C_WRITE,   5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("sub",    32'h40000033, FMT_R, 0, C_WRITE,   5'h01, RES_ALU, CSR_NONE, 32'h0);
    add_row("slt",    32'h00002033, FMT_R, 0, C_WRITE,   5'h0a, RES_ALU, CSR_NONE, 32'h0);
    add_row("sltu",   32'h00003033, FMT_R, 0, C_WRITE,   5'h0b, RES_ALU, CSR_NONE, 32'h0);
    add_row("sra",    32'h40005033, FMT_R, 0, C_WRITE,   5'h16, RES_ALU, CSR_NONE, 32'h0);
    add_row("xori",   32'hfff04013, FMT_I, 0, C_ARITH_I, 5'h02, RES_ALU, CSR_NONE, 32'hffffffff);
    add_row("andi",   32'h7f007013, FMT_I, 0, C_ARITH_I, 5'h04, RES_ALU, CSR_NONE, 32'h000007f0);
    add_row("addi",   32'h80000013, FMT_I, 0, C_ARITH_I, 5'h00, RES_ALU, CSR_NONE, 32'hfffff800);
    add_row("slli",   32'h00501013, FMT_I, 0, C_ARITH_I, 5'h05, RES_ALU, CSR_NONE, 32'h00000005);
    add_row("srli",   32'h01f05013, FMT_I, 0, C_ARITH_I, 5'h06, RES_ALU, CSR_NONE, 32'h0000001f);
    // srai keeps funct7 in the upper immediate bits
    add_row("srai",   32'h40305013, FMT_I, 0, C_ARITH_I, 5'h16, RES_ALU, CSR_NONE, 32'h00000403);
    add_row("lw",     32'h00402003, FMT_I, 0, C_LOAD,  5'h00, RES_MEMORY, CSR_NONE, 32'h00000004);
    add_row("lbu",    32'hfff04003, FMT_I, 0, C_LOAD,  5'h00, RES_MEMORY, CSR_NONE, 32'hffffffff);
    add_row("sw",     32'h00002423, FMT_S, 0, C_STORE,   5'h00, RES_ALU, CSR_NONE, 32'h00000008);
    add_row("sb",     32'hfe000e23, FMT_S, 0, C_STORE,   5'h00, RES_ALU, CSR_NONE, 32'hfffffffc);
    add_row("beq",    32'h00000863, FMT_S, 0, C_BRANCH,  5'h08, RES_ALU, CSR_NONE, 32'h00000010);
    add_row("bne",    32'hfe001ce3, FMT_S, 0, C_BRANCH,  5'h09, RES_ALU, CSR_NONE, 32'hfffffff8);
    add_row("blt",    32'h00004863, FMT_S, 0, C_BRANCH,  5'h0a, RES_ALU, CSR_NONE, 32'h00000010);
    add_row("bge",    32'hfe005ce3, FMT_S, 0, C_BRANCH,  5'h0c, RES_ALU, CSR_NONE, 32'hfffffff8);
    add_row("bltu",   32'h00006863, FMT_S, 0, C_BRANCH,  5'h0b, RES_ALU, CSR_NONE, 32'h00000010);
    add_row("bgeu",   32'hfe007ce3, FMT_S, 0, C_BRANCH,  5'h0d, RES_ALU, CSR_NONE, 32'hfffffff8);
    add_row("jal",    32'hffdff0ef, FMT_N, 0, C_JAL,   5'h00, RES_PC_P4, CSR_NONE, 32'hfffffffc);
    add_row("jalr",   32'h00c00067, FMT_I, 0, C_JALR,  5'h00, RES_PC_P4, CSR_NONE, 32'h0000000c);
    add_row("lui",    32'h123452b7, FMT_N, 0, C_ARITH_I, 5'h00, RES_ALU, CSR_NONE, 32'h12345000);
    add_row("auipc",  32'hfffff197, FMT_N, 0, C_AUIPC,   5'h00, RES_ALU, CSR_NONE, 32'hfffff000);
    add_row("csrrw",  32'h300312f3, FMT_N, 0, C_WRITE,   5'h00, RES_ALU, CSR_RW,   32'h0);
    add_row("csrrs",  32'h3053a073, FMT_N, 0, C_WRITE,   5'h00, RES_ALU, CSR_RS,   32'h0);
    add_row("csrrc",  32'h341130f3, FMT_N, 0, C_WRITE,   5'h00, RES_ALU, CSR_RC,   32'h0);
    add_row("csrrwi", 32'h340ad173, FMT_N, 0, C_CSR_I,   5'h00, RES_ALU, CSR_RW,   32'h00000015);
    add_row("csrrsi", 32'hc00fe1f3, FMT_N, 0, C_CSR_I,   5'h00, RES_ALU, CSR_RS,   32'h0000001f);
    add_row("csrrci", 32'h7c00f273, FMT_N, 0, C_CSR_I,   5'h00, RES_ALU, CSR_RC,   32'h00000001);
    add_row("c.li",   32'h00004501, FMT_N, 0, C_INV,     5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("add f7", 32'h02000033, FMT_R, 0, C_INV,     5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("ecall",  32'h00000073, FMT_N, 0, C_INV,     5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("ebreak", 32'h00100073, FMT_N, 0, C_INV,     5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("sys f3", 32'h00004073, FMT_N, 0, C_INV,     5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("zero",   32'h00000000, FMT_N, 0, C_NONE,    5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("fence",  32'h0ff0000f, FMT_N, 0, C_NONE,    5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("fence.i", 32'h0000100f, FMT_N, 0, C_NONE,   5'h00, RES_ALU, CSR_NONE, 32'h0);
    // flushed addi leaves a bubble
    add_row("flush",  32'h06400093, FMT_I, 1, C_NONE,    5'h00, RES_ALU, CSR_NONE, 32'h0);
    add_row("ori",    32'h0f006013, FMT_I, 0, C_ARITH_I, 5'h03, RES_ALU, CSR_NONE, 32'h000000f0);
endtask

// File: test/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb
    import rv_decode_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int SPARE_CYCLES = 10;
    // which register fields of a row get random indices
    localparam int FMT_N = 0;
    localparam int FMT_R = 1;
    localparam int FMT_I = 2;
    localparam int FMT_S = 3;

    logic                  i_clk = 1'b0;
    logic                  i_reset;
    logic                  i_flush;
    logic [XLEN-1:0]       i_instr;
    logic [REG_IDX_W-1:0]  o_rs1, o_rs2, o_rd;
    logic [XLEN-1:0]       o_imm;
    logic                  o_reg_write, o_mem_read, o_mem_write;
    logic                  o_jump, o_jump_imm, o_branch, o_pc_sel;
    logic                  o_alu_op1_sel, o_alu_op2_sel;
    logic [FUNCT3_W-1:0]   o_funct3;
    logic [ALU_CTRL_W-1:0] o_alu_ctrl;
    res_src_e              o_res_src;
    logic [CSR_IDX_W-1:0]  o_csr_idx;
    csr_op_e               o_csr_op;
    logic                  o_csr_sel;
    logic                  o_inv_instr;

    string       q_name[$];
    logic [31:0] q_instr[$];
    int          q_fmt[$];
    logic        q_flush[$];
    logic [10:0] q_ctrl[$];
    logic [4:0]  q_alu[$];
    res_src_e    q_res[$];
    csr_op_e     q_csr[$];
    logic [31:0] q_imm[$];

    integer seed;
    int     num_rows;
    int     tests_run;
    int     tests_failed;
    int     row_errors;
    int     mismatches;
    logic   table_ready = 1'b0;
    string  cur_name;

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    decode_stage UUT
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_flush       (i_flush),
        .i_instr       (i_instr),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_imm         (o_imm),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_jump_imm    (o_jump_imm),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_funct3      (o_funct3),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_res_src     (o_res_src),
        .o_csr_idx     (o_csr_idx),
        .o_csr_op      (o_csr_op),
        .o_csr_sel     (o_csr_sel),
        .o_inv_instr   (o_inv_instr)
    );

    task automatic add_row(input string name, input logic [31:0] instr, input int fmt,
                           input int flush, input logic [10:0] ctrl, input logic [4:0] alu,
                           input res_src_e res, input csr_op_e csr, input logic [31:0] imm);
        q_name.push_back(name);
        q_instr.push_back(instr);
        q_fmt.push_back(fmt);
        q_flush.push_back(flush != 0);
        q_ctrl.push_back(ctrl);
        q_alu.push_back(alu);
        q_res.push_back(res);
        q_csr.push_back(csr);
        q_imm.push_back(imm);
    endtask

    `include "decode_vectors.svh"

    // rd at 11..7, rs1 at 19..15, rs2 at 24..20
    function automatic logic [31:0] field_mask(input int fmt);
        case (fmt)
        FMT_R:   return 32'h01ff_8f80;
        FMT_I:   return 32'h000f_8f80;
        FMT_S:   return 32'h01ff_8000;
        default: return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string field, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t ns: %s %s is %h, expected %h",
                     $time, cur_name, field, actual, expected);
            row_errors++;
            mismatches++;
        end
    endtask

    task automatic check_outputs(input logic bubble, input logic [31:0] word,
                                 input logic [10:0] ctrl, input logic [4:0] alu,
                                 input res_src_e res, input csr_op_e csr,
                                 input logic [31:0] imm);
        logic [31:0] exp_rs1 = '0;
        logic [31:0] exp_rs2 = '0;
        logic [31:0] exp_rd = '0;
        logic [31:0] exp_funct3 = '0;
        logic [31:0] exp_csr_idx = '0;
        if (!bubble)
        begin
            // lui has no rs1 and reports register 0
            exp_rs1     = (word[6:0] == 7'b0110111) ? 32'h0 : 32'(word[19:15]);
            exp_rs2     = 32'(word[24:20]);
            exp_rd      = 32'(word[11:7]);
            exp_funct3  = 32'(word[14:12]);
            exp_csr_idx = 32'(word[31:20]);
        end
        check_value("rs1", 32'(o_rs1), exp_rs1);
        check_value("rs2", 32'(o_rs2), exp_rs2);
        check_value("rd", 32'(o_rd), exp_rd);
        check_value("funct3", 32'(o_funct3), exp_funct3);
        check_value("csr_idx", 32'(o_csr_idx), exp_csr_idx);
        check_value("imm", o_imm, imm);
        check_value("alu_ctrl", 32'(o_alu_ctrl), 32'(alu));
        check_value("res_src", 32'(o_res_src), 32'(res));
        check_value("csr_op", 32'(o_csr_op), 32'(csr));
        check_value("reg_write", 32'(o_reg_write), 32'(ctrl[10]));
        check_value("mem_read", 32'(o_mem_read), 32'(ctrl[9]));
        check_value("mem_write", 32'(o_mem_write), 32'(ctrl[8]));
        check_value("jump", 32'(o_jump), 32'(ctrl[7]));
        check_value("jump_imm", 32'(o_jump_imm), 32'(ctrl[6]));
        check_value("branch", 32'(o_branch), 32'(ctrl[5]));
        check_value("pc_sel", 32'(o_pc_sel), 32'(ctrl[4]));
        check_value("alu_op1_sel", 32'(o_alu_op1_sel), 32'(ctrl[3]));
        check_value("alu_op2_sel", 32'(o_alu_op2_sel), 32'(ctrl[2]));
        check_value("csr_sel", 32'(o_csr_sel), 32'(ctrl[1]));
        check_value("inv_instr", 32'(o_inv_instr), 32'(ctrl[0]));
    endtask

    task automatic report_test(input int index);
        tests_run++;
        if (row_errors == 0)
            $display("test %0d %s: ok", index, cur_name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", index, cur_name, row_errors);
        end
    endtask

    initial
    begin : stimulus
        int          i;
        logic [31:0] word;
        i_reset      = 1'b1;
        i_flush      = 1'b0;
        i_instr      = '0;
        seed         = 32'h5d293c6b;
        tests_run    = 0;
        tests_failed = 0;
        mismatches   = 0;
        load_vectors();
        num_rows     = q_name.size();
        table_ready  = 1'b1;

        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        cur_name   = "reset";
        row_errors = 0;
        check_outputs(1'b1, '0, C_NONE, 5'h00, RES_ALU, CSR_NONE, '0);
        report_test(0);
        i_reset = 1'b0;

        // drive on the falling edge, check one cycle later
        for (i = 0; i < num_rows; i++)
        begin
            word    = q_instr[i] | ($random(seed) & field_mask(q_fmt[i]));
            i_instr = word;
            i_flush = q_flush[i];
            @(posedge i_clk);
            @(negedge i_clk);
            cur_name   = q_name[i];
            row_errors = 0;
            check_outputs(q_flush[i], word, q_ctrl[i], q_alu[i], q_res[i], q_csr[i], q_imm[i]);
            report_test(i + 1);
        end
        i_flush = 1'b0;

        $display("tests run %0d, passed %0d, failed %0d, mismatches %0d",
                 tests_run, tests_run - tests_failed, tests_failed, mismatches);
        if (tests_failed == 0 && mismatches == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin : watchdog
        wait (table_ready);
        #((RESET_CYCLES + num_rows + SPARE_CYCLES) * CLK_PERIOD);
        $display("timeout: the decode tests did not complete in the allowed time");
        $display("Finished with errors");
        $finish;
    end

endmodule
